/* smem_settings.svh */
`ifndef SMEM_SETTINGS_SVH
`define SMEM_SETTINGS_SVH

// ------------------------------
// widths
`define SMEM_CL          512 // one load line
`define SMEM_IDX_W       32  // index position / occ count
`define SMEM_READ_NUM_W  6
`define SMEM_LEN_W       7   // read length and step count

// ------------------------------
// depths
`define SMEM_MAX_READ    64
`define SMEM_MAX_LEN     64  // bases per read
`define SMEM_RES_DEPTH   4

// ------------------------------
// occ requester ids
`define SMEM_ID_W        1
`define SMEM_ID_FWD      1'b0
`define SMEM_ID_BWD      1'b1

`endif

/* bwt_pkg.sv */
`include "smem_settings.svh"

package bwt_pkg;

	// 2-bit nucleotide code, A C G T
	typedef logic [1:0] base_t;

	// suffix-array interval
	typedef struct packed {
		logic [`SMEM_IDX_W-1:0] k;
		logic [`SMEM_IDX_W-1:0] l;
	} interval_t;

	// one count per base, index is the base code
	typedef logic [3:0][`SMEM_IDX_W-1:0] occ_counts_t;

	typedef enum logic {
		DIR_FWD = 1'b0,
		DIR_BWD = 1'b1
	} dir_e;

	typedef logic [`SMEM_ID_W-1:0] req_id_t;

	// one word on the result stream
	typedef struct packed {
		logic [`SMEM_READ_NUM_W-1:0] read_num;
		dir_e                        dir;
		logic [`SMEM_LEN_W-1:0]      steps; // bases consumed
		logic [`SMEM_IDX_W-1:0]      k;
		logic [`SMEM_IDX_W-1:0]      l;
	} result_t;

endpackage

/* load_pkg.sv */
`include "smem_settings.svh"

package load_pkg;

	localparam int PARAM_PAD_W = `SMEM_CL - 6 * `SMEM_IDX_W;
	localparam int READ_PAD_W  = `SMEM_CL - `SMEM_READ_NUM_W - `SMEM_LEN_W - 2 * `SMEM_MAX_LEN;

	// first line of a batch, primary sits in the low bits
	typedef struct packed {
		logic [PARAM_PAD_W-1:0]      pad;
		logic [3:0][`SMEM_IDX_W-1:0] l2;      // base offsets, l2[0] lowest
		logic [`SMEM_IDX_W-1:0]      seq_len;
		logic [`SMEM_IDX_W-1:0]      primary;
	} param_line_t;

	// every later line, base 0 in the low bits
	typedef struct packed {
		logic [READ_PAD_W-1:0]                  pad;
		bwt_pkg::base_t [`SMEM_MAX_LEN-1:0]     bases;
		logic [`SMEM_LEN_W-1:0]                 len;
		logic [`SMEM_READ_NUM_W-1:0]            read_num;
	} read_line_t;

	// same 512 bits, meaning depends on line order
	typedef union packed {
		param_line_t params;
		read_line_t  read;
	} load_line_u;

	typedef struct packed {
		logic [`SMEM_READ_NUM_W-1:0]        read_num;
		logic [`SMEM_LEN_W-1:0]             len;
		bwt_pkg::base_t [`SMEM_MAX_LEN-1:0] bases;
	} read_entry_t;

	typedef struct packed {
		logic [`SMEM_IDX_W-1:0]      primary;
		logic [`SMEM_IDX_W-1:0]      seq_len;
		logic [3:0][`SMEM_IDX_W-1:0] l2;
	} index_params_t;

endpackage

/* read_store.sv */
`timescale 1ns/10ps
`include "smem_settings.svh"

module read_store (
	input  logic                        clk_32ui_i,
	input  logic                        rst_i,

	input  logic                        load_valid_i,
	input  load_pkg::load_line_u        load_data_i,
	input  logic [`SMEM_READ_NUM_W:0]   batch_size_i,

	input  logic [`SMEM_READ_NUM_W-1:0] fwd_idx_i,
	input  logic [`SMEM_READ_NUM_W-1:0] bwd_idx_i,
	output load_pkg::read_entry_t       fwd_read_o,
	output load_pkg::read_entry_t       bwd_read_o,

	output load_pkg::index_params_t     params_o,
	output logic                        load_done_o
);

	localparam int CNT_W = `SMEM_READ_NUM_W + 1;

	load_pkg::read_entry_t reads_q [`SMEM_MAX_READ];

	logic             param_seen_q; // first line already taken
	logic [CNT_W-1:0] read_cnt_q;
	logic             take_line;
	logic             read_wr;

	assign take_line = load_valid_i && !load_done_o;
	assign read_wr   = take_line && param_seen_q;

	// ------------------------------
	// line order and done flag
	always_ff @(posedge clk_32ui_i) begin
		if (rst_i) begin
			param_seen_q <= 1'b0;
			read_cnt_q   <= '0;
			load_done_o  <= 1'b0;
		end else if (take_line) begin
			if (!param_seen_q) begin
				param_seen_q <= 1'b1;
			end else begin
				read_cnt_q <= read_cnt_q + 1'b1;
				if ((read_cnt_q + 1'b1) == batch_size_i)
					load_done_o <= 1'b1; // last read line in
			end
		end
	end

	// ------------------------------
	// parameter and read capture
	always_ff @(posedge clk_32ui_i) begin
		if (take_line && !param_seen_q) begin
			params_o.primary <= load_data_i.params.primary;
			params_o.seq_len <= load_data_i.params.seq_len;
			params_o.l2      <= load_data_i.params.l2;
		end
		if (read_wr) begin
			reads_q[read_cnt_q[`SMEM_READ_NUM_W-1:0]].read_num <= load_data_i.read.read_num;
			reads_q[read_cnt_q[`SMEM_READ_NUM_W-1:0]].len      <= load_data_i.read.len;
			reads_q[read_cnt_q[`SMEM_READ_NUM_W-1:0]].bases    <= load_data_i.read.bases;
		end
	end

	// two independent lookup ports
	assign fwd_read_o = reads_q[fwd_idx_i];
	assign bwd_read_o = reads_q[bwd_idx_i];

endmodule

/* bwt_extender.sv */
`timescale 1ns/10ps
`include "smem_settings.svh"

module bwt_extender #(
	parameter bwt_pkg::dir_e DIR = bwt_pkg::DIR_FWD
) (
	input  logic                        clk_32ui_i,
	input  logic                        rst_i,
	input  logic                        start_i,
	input  logic [`SMEM_READ_NUM_W:0]   batch_size_i,
	input  load_pkg::index_params_t     params_i,

	output logic [`SMEM_READ_NUM_W-1:0] read_idx_o,
	input  load_pkg::read_entry_t       read_i,

	output logic                        occ_req_o,
	output logic [`SMEM_IDX_W-1:0]      occ_pos_k_o,
	output logic [`SMEM_IDX_W-1:0]      occ_pos_l_o,
	input  logic                        occ_gnt_i,
	input  logic                        occ_valid_i,
	input  bwt_pkg::occ_counts_t        occ_k_i,
	input  bwt_pkg::occ_counts_t        occ_l_i,

	output logic                        res_valid_o,
	output bwt_pkg::result_t            res_o
);

	localparam int BI_W = $clog2(`SMEM_MAX_LEN);

	typedef enum logic [2:0] {S_IDLE, S_INIT, S_REQ, S_WAIT, S_DONE} state_e;

	state_e                    state_q;
	logic [`SMEM_READ_NUM_W:0] idx_q;
	logic [`SMEM_LEN_W-1:0]    steps_q;
	bwt_pkg::interval_t        ivl_q;
	bwt_pkg::interval_t        ivl_nx;
	logic [`SMEM_LEN_W-1:0]    bwd_sel;
	logic [`SMEM_LEN_W-1:0]    base_sel;
	bwt_pkg::base_t            base_raw;
	bwt_pkg::base_t            base_c;
	logic                      empty_nx;
	logic                      last_base;
	logic                      last_read;

	// query position skips the primary row
	function automatic logic [`SMEM_IDX_W-1:0] occ_pos(
		input logic [`SMEM_IDX_W-1:0] x,
		input logic [`SMEM_IDX_W-1:0] primary
	);
		return (x > primary) ? x - 1'b1 : x;
	endfunction

	// ------------------------------
	// base select, by direction
	assign bwd_sel  = read_i.len - steps_q - 1'b1; // walk from the tail
	assign base_sel = (DIR == bwt_pkg::DIR_FWD) ? steps_q : bwd_sel;
	assign base_raw = read_i.bases[base_sel[BI_W-1:0]];
	assign base_c   = (DIR == bwt_pkg::DIR_FWD) ? 2'd3 - base_raw : base_raw;

	assign ivl_nx.k  = params_i.l2[base_c] + occ_k_i[base_c];
	assign ivl_nx.l  = params_i.l2[base_c] + occ_l_i[base_c];
	assign empty_nx  = (ivl_nx.l <= ivl_nx.k);
	assign last_base = ((steps_q + 1'b1) == read_i.len);
	assign last_read = ((idx_q + 1'b1) == batch_size_i);

	assign read_idx_o  = idx_q[`SMEM_READ_NUM_W-1:0];
	assign occ_req_o   = (state_q == S_REQ); // held until granted
	assign occ_pos_k_o = occ_pos(ivl_q.k, params_i.primary);
	assign occ_pos_l_o = occ_pos(ivl_q.l, params_i.primary);

	// ------------------------------
	// read walk FSM
	always_ff @(posedge clk_32ui_i) begin
		if (rst_i) begin
			state_q     <= S_IDLE;
			idx_q       <= '0;
			res_valid_o <= 1'b0;
		end else begin
			res_valid_o <= 1'b0;
			case (state_q)
				S_IDLE: if (start_i)
					state_q <= (batch_size_i == '0) ? S_DONE : S_INIT;
				S_INIT: begin
					if (read_i.len == '0) begin // nothing to walk
						res_valid_o <= 1'b1;
						idx_q       <= idx_q + 1'b1;
						state_q     <= last_read ? S_DONE : S_INIT;
					end else begin
						state_q <= S_REQ;
					end
				end
				S_REQ: if (occ_gnt_i)
					state_q <= S_WAIT;
				S_WAIT: if (occ_valid_i) begin
					if (empty_nx || last_base) begin
						res_valid_o <= 1'b1;
						idx_q       <= idx_q + 1'b1;
						state_q     <= last_read ? S_DONE : S_INIT;
					end else begin
						state_q <= S_REQ;
					end
				end
				S_DONE: state_q <= S_DONE; // batch finished
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// interval, step count and result word
	always_ff @(posedge clk_32ui_i) begin
		if (state_q == S_INIT) begin
			ivl_q.k        <= '0;
			ivl_q.l        <= params_i.seq_len;
			steps_q        <= '0;
			res_o.read_num <= read_i.read_num;
			res_o.dir      <= DIR;
			res_o.steps    <= '0;
			res_o.k        <= '0;
			res_o.l        <= params_i.seq_len;
		end else if (state_q == S_WAIT && occ_valid_i) begin
			res_o.read_num <= read_i.read_num;
			res_o.dir      <= DIR;
			if (empty_nx) begin // keep the last non-empty interval
				res_o.steps <= steps_q;
				res_o.k     <= ivl_q.k;
				res_o.l     <= ivl_q.l;
			end else begin
				ivl_q       <= ivl_nx;
				steps_q     <= steps_q + 1'b1;
				res_o.steps <= steps_q + 1'b1;
				res_o.k     <= ivl_nx.k;
				res_o.l     <= ivl_nx.l;
			end
		end
	end

endmodule

/* occ_arbiter.sv */
`timescale 1ns/10ps
`include "smem_settings.svh"

module occ_arbiter (
	input  logic                   clk_32ui_i,
	input  logic                   rst_i,

	input  logic                   fwd_req_i,
	input  logic [`SMEM_IDX_W-1:0] fwd_pos_k_i,
	input  logic [`SMEM_IDX_W-1:0] fwd_pos_l_i,
	output logic                   fwd_gnt_o,
	output logic                   fwd_valid_o,

	input  logic                   bwd_req_i,
	input  logic [`SMEM_IDX_W-1:0] bwd_pos_k_i,
	input  logic [`SMEM_IDX_W-1:0] bwd_pos_l_i,
	output logic                   bwd_gnt_o,
	output logic                   bwd_valid_o,

	output logic                   dram_valid_o,
	output logic [`SMEM_IDX_W-1:0] addr_k_o,
	output logic [`SMEM_IDX_W-1:0] addr_l_o,
	output bwt_pkg::req_id_t       dram_id_o,

	input  logic                   dram_get_i,
	input  bwt_pkg::req_id_t       dram_id_i
);

	logic fwd_win;
	logic bwd_win;

	// a request still showing during its grant cycle is already served
	assign fwd_win = fwd_req_i && !fwd_gnt_o;
	assign bwd_win = bwd_req_i && !bwd_gnt_o && !fwd_win; // forward first

	always_ff @(posedge clk_32ui_i) begin
		if (rst_i) begin
			fwd_gnt_o    <= 1'b0;
			bwd_gnt_o    <= 1'b0;
			dram_valid_o <= 1'b0;
		end else begin
			fwd_gnt_o    <= fwd_win;
			bwd_gnt_o    <= bwd_win;
			dram_valid_o <= fwd_win || bwd_win;
		end
	end

	always_ff @(posedge clk_32ui_i) begin
		if (fwd_win || bwd_win) begin
			addr_k_o  <= fwd_win ? fwd_pos_k_i : bwd_pos_k_i;
			addr_l_o  <= fwd_win ? fwd_pos_l_i : bwd_pos_l_i;
			dram_id_o <= fwd_win ? `SMEM_ID_FWD : `SMEM_ID_BWD;
		end
	end

	// response routing by tag
	assign fwd_valid_o = dram_get_i && (dram_id_i == `SMEM_ID_FWD);
	assign bwd_valid_o = dram_get_i && (dram_id_i == `SMEM_ID_BWD);

endmodule

/* result_store.sv */
`timescale 1ns/10ps
`include "smem_settings.svh"

module result_store (
	input  logic                      clk_32ui_i,
	input  logic                      rst_i,
	input  logic [`SMEM_READ_NUM_W:0] batch_size_i,

	input  logic                      fwd_valid_i,
	input  bwt_pkg::result_t          fwd_res_i,
	input  logic                      bwd_valid_i,
	input  bwt_pkg::result_t          bwd_res_i,

	output logic                      output_valid_o,
	output bwt_pkg::result_t          output_data_o,
	output logic                      output_finish_o
);

	localparam int PTR_W = $clog2(`SMEM_RES_DEPTH);
	localparam int CNT_W = PTR_W + 1;
	localparam int OUT_W = `SMEM_READ_NUM_W + 2; // up to twice the batch

	bwt_pkg::result_t fifo_q [`SMEM_RES_DEPTH];

	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] wr_ptr_nx;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic [CNT_W-1:0] push_n;
	logic             pop;
	logic [OUT_W-1:0] out_cnt_q;
	logic [OUT_W-1:0] out_total;

	assign wr_ptr_nx = wr_ptr_q + 1'b1;
	assign push_n    = CNT_W'(fwd_valid_i) + CNT_W'(bwd_valid_i);
	assign pop       = (count_q != '0);
	assign out_total = {batch_size_i, 1'b0};

	// ------------------------------
	// dual push, single pop
	always_ff @(posedge clk_32ui_i) begin
		if (fwd_valid_i)
			fifo_q[wr_ptr_q] <= fwd_res_i;
		if (bwd_valid_i)
			fifo_q[fwd_valid_i ? wr_ptr_nx : wr_ptr_q] <= bwd_res_i; // lands behind fwd
		if (pop)
			output_data_o <= fifo_q[rd_ptr_q];
	end

	always_ff @(posedge clk_32ui_i) begin
		if (rst_i) begin
			wr_ptr_q        <= '0;
			rd_ptr_q        <= '0;
			count_q         <= '0;
			output_valid_o  <= 1'b0;
			out_cnt_q       <= '0;
			output_finish_o <= 1'b0;
		end else begin
			wr_ptr_q       <= wr_ptr_q + push_n[PTR_W-1:0];
			rd_ptr_q       <= rd_ptr_q + PTR_W'(pop);
			count_q        <= count_q + push_n - CNT_W'(pop);
			output_valid_o <= pop;
			if (output_valid_o) begin
				out_cnt_q <= out_cnt_q + 1'b1;
				if ((out_cnt_q + 1'b1) == out_total)
					output_finish_o <= 1'b1; // all 2 x batch results out
			end
		end
	end

endmodule

/* smem_top.sv */
`timescale 1ns/10ps
`include "smem_settings.svh"

module smem_top (
	input  logic                      clk_32ui_i,
	input  logic                      rst_i,

	input  logic                      load_valid_i,
	input  load_pkg::load_line_u      load_data_i,
	input  logic [`SMEM_READ_NUM_W:0] batch_size_i,
	output logic                      load_done_o,

	output logic                      dram_valid_o,
	output logic [`SMEM_IDX_W-1:0]    addr_k_o,
	output logic [`SMEM_IDX_W-1:0]    addr_l_o,
	output bwt_pkg::req_id_t          dram_id_o,
	input  logic                      dram_get_i,
	input  bwt_pkg::req_id_t          dram_id_i,
	input  bwt_pkg::occ_counts_t      occ_k_i,
	input  bwt_pkg::occ_counts_t      occ_l_i,

	output logic                      output_valid_o,
	output bwt_pkg::result_t          output_data_o,
	output logic                      output_finish_o
);

	// read store to extenders
	logic [`SMEM_READ_NUM_W-1:0] fwd_idx;
	logic [`SMEM_READ_NUM_W-1:0] bwd_idx;
	load_pkg::read_entry_t       fwd_read;
	load_pkg::read_entry_t       bwd_read;
	load_pkg::index_params_t     params;

	// extenders to arbiter
	logic                   fwd_req;
	logic                   bwd_req;
	logic [`SMEM_IDX_W-1:0] fwd_pos_k;
	logic [`SMEM_IDX_W-1:0] fwd_pos_l;
	logic [`SMEM_IDX_W-1:0] bwd_pos_k;
	logic [`SMEM_IDX_W-1:0] bwd_pos_l;
	logic                   fwd_gnt;
	logic                   bwd_gnt;
	logic                   fwd_occ_valid;
	logic                   bwd_occ_valid;

	// extenders to result store
	logic             fwd_res_valid;
	logic             bwd_res_valid;
	bwt_pkg::result_t fwd_res;
	bwt_pkg::result_t bwd_res;

	read_store u_read_store (
		.clk_32ui_i   (clk_32ui_i),
		.rst_i        (rst_i),
		.load_valid_i (load_valid_i),
		.load_data_i  (load_data_i),
		.batch_size_i (batch_size_i),
		.fwd_idx_i    (fwd_idx),
		.bwd_idx_i    (bwd_idx),
		.fwd_read_o   (fwd_read),
		.bwd_read_o   (bwd_read),
		.params_o     (params),
		.load_done_o  (load_done_o)
	);

	bwt_extender #(.DIR(bwt_pkg::DIR_FWD)) u_fwd (
		.clk_32ui_i   (clk_32ui_i),
		.rst_i        (rst_i),
		.start_i      (load_done_o),
		.batch_size_i (batch_size_i),
		.params_i     (params),
		.read_idx_o   (fwd_idx),
		.read_i       (fwd_read),
		.occ_req_o    (fwd_req),
		.occ_pos_k_o  (fwd_pos_k),
		.occ_pos_l_o  (fwd_pos_l),
		.occ_gnt_i    (fwd_gnt),
		.occ_valid_i  (fwd_occ_valid),
		.occ_k_i      (occ_k_i),
		.occ_l_i      (occ_l_i),
		.res_valid_o  (fwd_res_valid),
		.res_o        (fwd_res)
	);

	bwt_extender #(.DIR(bwt_pkg::DIR_BWD)) u_bwd (
		.clk_32ui_i   (clk_32ui_i),
		.rst_i        (rst_i),
		.start_i      (load_done_o),
		.batch_size_i (batch_size_i),
		.params_i     (params),
		.read_idx_o   (bwd_idx),
		.read_i       (bwd_read),
		.occ_req_o    (bwd_req),
		.occ_pos_k_o  (bwd_pos_k),
		.occ_pos_l_o  (bwd_pos_l),
		.occ_gnt_i    (bwd_gnt),
		.occ_valid_i  (bwd_occ_valid),
		.occ_k_i      (occ_k_i),
		.occ_l_i      (occ_l_i),
		.res_valid_o  (bwd_res_valid),
		.res_o        (bwd_res)
	);

	occ_arbiter u_occ_arbiter (
		.clk_32ui_i   (clk_32ui_i),
		.rst_i        (rst_i),
		.fwd_req_i    (fwd_req),
		.fwd_pos_k_i  (fwd_pos_k),
		.fwd_pos_l_i  (fwd_pos_l),
		.fwd_gnt_o    (fwd_gnt),
		.fwd_valid_o  (fwd_occ_valid),
		.bwd_req_i    (bwd_req),
		.bwd_pos_k_i  (bwd_pos_k),
		.bwd_pos_l_i  (bwd_pos_l),
		.bwd_gnt_o    (bwd_gnt),
		.bwd_valid_o  (bwd_occ_valid),
		.dram_valid_o (dram_valid_o),
		.addr_k_o     (addr_k_o),
		.addr_l_o     (addr_l_o),
		.dram_id_o    (dram_id_o),
		.dram_get_i   (dram_get_i),
		.dram_id_i    (dram_id_i)
	);

	result_store u_result_store (
		.clk_32ui_i      (clk_32ui_i),
		.rst_i           (rst_i),
		.batch_size_i    (batch_size_i),
		.fwd_valid_i     (fwd_res_valid),
		.fwd_res_i       (fwd_res),
		.bwd_valid_i     (bwd_res_valid),
		.bwd_res_i       (bwd_res),
		.output_valid_o  (output_valid_o),
		.output_data_o   (output_data_o),
		.output_finish_o (output_finish_o)
	);

endmodule

/* tb_smem_chk.sv */
`timescale 1ns/10ps

module tb_smem_chk (
	input logic             clk_i,
	input logic             rst_i,
	input logic             dram_valid_i,
	input bwt_pkg::req_id_t dram_id_i,
	input logic             dram_get_i,
	input bwt_pkg::req_id_t resp_id_i,
	input logic             load_done_i,
	input logic             out_valid_i,
	input logic             out_finish_i
);

	int         fail_cnt = 0;
	logic [1:0] pend_q; // one bit per requester id

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pend_q <= '0;
		end else begin
			if (dram_get_i)
				pend_q[resp_id_i] <= 1'b0;
			if (dram_valid_i)
				pend_q[dram_id_i] <= 1'b1;
		end
	end

	// ------------------------------
	a_one_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
		dram_valid_i |-> !pend_q[dram_id_i])
		else begin
			fail_cnt++;
			$error("memory request repeated for an id with no response between");
		end

	a_no_early_output: assert property (@(posedge clk_i) disable iff (rst_i)
		out_valid_i |-> load_done_i)
		else begin
			fail_cnt++;
			$error("output strobe before load done");
		end

	a_quiet_after_finish: assert property (@(posedge clk_i) disable iff (rst_i)
		out_finish_i |-> !out_valid_i)
		else begin
			fail_cnt++;
			$error("output strobe after finish");
		end

	a_reset_low: assert property (@(posedge clk_i)
		rst_i |=> !dram_valid_i && !out_valid_i && !load_done_i && !out_finish_i)
		else begin
			fail_cnt++;
			$error("control output high during reset");
		end

endmodule

bind smem_top tb_smem_chk u_chk (
	.clk_i        (clk_32ui_i),
	.rst_i        (rst_i),
	.dram_valid_i (dram_valid_o),
	.dram_id_i    (dram_id_o),
	.dram_get_i   (dram_get_i),
	.resp_id_i    (dram_id_i),
	.load_done_i  (load_done_o),
	.out_valid_i  (output_valid_o),
	.out_finish_i (output_finish_o)
);

/* tb_smem.sv */
`timescale 1ns/10ps
`include "smem_settings.svh"

module tb_smem;

	localparam int BATCH       = 20;
	localparam int LOAD_CYCLES = (BATCH + 1) * 6 + 10;
	localparam int WD_CYCLES   = BATCH * 2 * 64 * 10 + LOAD_CYCLES;

	logic                        clk;
	logic                        rst;
	logic                        load_valid_i;
	load_pkg::load_line_u        load_data_i;
	logic [`SMEM_READ_NUM_W:0]   batch_size_i;
	logic                        load_done_o;
	logic                        dram_valid_o;
	logic [`SMEM_IDX_W-1:0]      addr_k_o;
	logic [`SMEM_IDX_W-1:0]      addr_l_o;
	bwt_pkg::req_id_t            dram_id_o;
	logic                        dram_get_i;
	bwt_pkg::req_id_t            dram_id_i;
	bwt_pkg::occ_counts_t        occ_k_i;
	bwt_pkg::occ_counts_t        occ_l_i;
	logic                        output_valid_o;
	bwt_pkg::result_t            output_data_o;
	logic                        output_finish_o;

	logic [31:0]                 lfsr_q = 32'ha77b;
	load_pkg::index_params_t     prm;
	load_pkg::read_line_t        reads [BATCH];
	bwt_pkg::result_t            exp_res [2][BATCH];
	logic                        seen [2][BATCH];
	int                          early [2]; // reads that empty before the last base
	int                          out_count = 0;

	smem_top u_dut (
		.clk_32ui_i      (clk),
		.rst_i           (rst),
		.load_valid_i    (load_valid_i),
		.load_data_i     (load_data_i),
		.batch_size_i    (batch_size_i),
		.load_done_o     (load_done_o),
		.dram_valid_o    (dram_valid_o),
		.addr_k_o        (addr_k_o),
		.addr_l_o        (addr_l_o),
		.dram_id_o       (dram_id_o),
		.dram_get_i      (dram_get_i),
		.dram_id_i       (dram_id_i),
		.occ_k_i         (occ_k_i),
		.occ_l_i         (occ_l_i),
		.output_valid_o  (output_valid_o),
		.output_data_o   (output_data_o),
		.output_finish_o (output_finish_o)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// ------------------------------
	// helpers
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v      = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	// index memory count rule
	function automatic logic [31:0] occ_count(input logic [31:0] x, input int c);
		logic [31:0] prod;
		prod = x * 32'(c + 1);
		return prod >> 2;
	endfunction

	function automatic bwt_pkg::result_t ref_extend(
		input load_pkg::index_params_t p,
		input load_pkg::read_line_t    r,
		input bwt_pkg::dir_e           dir
	);
		bwt_pkg::result_t res;
		logic [31:0]      k;
		logic [31:0]      l;
		logic [31:0]      pk;
		logic [31:0]      pl;
		logic [31:0]      nk;
		logic [31:0]      nl;
		int               b;
		int               c;
		int               n;
		logic             stop;
		k    = '0;
		l    = p.seq_len;
		n    = 0;
		stop = 1'b0;
		for (int i = 0; i < int'(r.len) && !stop; i++) begin
			if (dir == bwt_pkg::DIR_FWD) begin
				b = int'(r.bases[i]);
				c = 3 - b; // complement
			end else begin
				b = int'(r.bases[int'(r.len) - 1 - i]);
				c = b;
			end
			pk = (k > p.primary) ? k - 1 : k;
			pl = (l > p.primary) ? l - 1 : l;
			nk = p.l2[c] + occ_count(pk, c);
			nl = p.l2[c] + occ_count(pl, c);
			if (nl <= nk) begin
				stop = 1'b1;
			end else begin
				k = nk;
				l = nl;
				n++;
			end
		end
		res          = '0;
		res.read_num = r.read_num;
		res.dir      = dir;
		res.steps    = n[`SMEM_LEN_W-1:0];
		res.k        = k;
		res.l        = l;
		return res;
	endfunction

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	// ------------------------------
	// compare tasks
	task automatic check_result(input string name, input bwt_pkg::result_t exp,
			input bwt_pkg::result_t act);
		if (act !== exp)
			fail_run($sformatf(
				"Mismatch %s: expected steps %0d k %0d l %0d, actual steps %0d k %0d l %0d",
				name, exp.steps, exp.k, exp.l, act.steps, act.k, act.l));
	endtask

	task automatic check_load_done(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("Mismatch %s: expected load_done %0b actual %0b",
				name, exp, act));
	endtask

	task automatic check_finish(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("Mismatch %s: expected finish %0b actual %0b",
				name, exp, act));
	endtask

	// ------------------------------
	// stimulus
	task automatic build_batch();
		load_pkg::read_line_t r;
		int                   len;
		for (int i = 0; i < BATCH; i++) begin
			r          = '0;
			r.read_num = i[`SMEM_READ_NUM_W-1:0];
			case (i)
				0, 1, 3: len = 64;
				2:       len = 1;
				default: len = int'(take_bits(6)) + 1; // 1 to 64
			endcase
			r.len = len[`SMEM_LEN_W-1:0];
			for (int b = 0; b < `SMEM_MAX_LEN; b++) begin
				case (i)
					0:       r.bases[b] = 2'd3; // forward narrows fast
					1:       r.bases[b] = 2'd0; // backward narrows fast
					2:       r.bases[b] = 2'd2;
					3:       r.bases[b] = b[1:0];
					default: r.bases[b] = take_bits(2);
				endcase
			end
			reads[i] = r;
			for (int d = 0; d < 2; d++) begin
				exp_res[d][i] = ref_extend(prm, r, bwt_pkg::dir_e'(d));
				seen[d][i]    = 1'b0;
				if (int'(exp_res[d][i].steps) < len)
					early[d]++;
			end
		end
	endtask

	task automatic send_line(input load_pkg::load_line_u line, input logic exp_done,
			input string name);
		@(posedge clk);
		#1;
		load_valid_i = 1'b1;
		load_data_i  = line;
		@(posedge clk);
		#1;
		load_valid_i = 1'b0;
		@(negedge clk);
		check_load_done(name, exp_done, load_done_o);
		repeat (int'(take_bits(2))) @(posedge clk); // idle gap
	endtask

	initial begin
		load_pkg::load_line_u line;
		int                   missing;
		load_valid_i = 1'b0;
		load_data_i  = '0;
		batch_size_i = BATCH;
		rst          = 1'b1;
		early[0]     = 0;
		early[1]     = 0;
		prm.primary  = 32'd377;
		prm.seq_len  = 32'd1000;
		prm.l2[0]    = 32'd1;
		prm.l2[1]    = 32'd260;
		prm.l2[2]    = 32'd510;
		prm.l2[3]    = 32'd760;
		build_batch();

		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		check_load_done("after reset", 1'b0, load_done_o);

		line                = '0;
		line.params.primary = prm.primary;
		line.params.seq_len = prm.seq_len;
		line.params.l2      = prm.l2;
		send_line(line, 1'b0, "after parameter line");
		for (int i = 0; i < BATCH; i++) begin
			line      = '0;
			line.read = reads[i];
			send_line(line, i == BATCH - 1, $sformatf("after read line %0d", i));
		end

		while (!output_finish_o)
			@(negedge clk);
		repeat (20) @(negedge clk); // quiet period after finish

		missing = 0;
		for (int d = 0; d < 2; d++)
			for (int i = 0; i < BATCH; i++)
				if (!seen[d][i])
					missing++;
		if (missing == 0 && early[0] > 0 && early[1] > 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			fail_run($sformatf("%0d results missing, early stops fwd %0d bwd %0d",
				missing, early[0], early[1]));
		end
	end

	// ------------------------------
	// index memory model with one pending slot per id
	initial begin
		logic        pend [2];
		int          wait_cnt [2];
		logic [31:0] pos_k [2];
		logic [31:0] pos_l [2];
		logic        sent;
		int          first;
		int          id;
		dram_get_i = 1'b0;
		dram_id_i  = '0;
		occ_k_i    = '0;
		occ_l_i    = '0;
		pend[0]    = 1'b0;
		pend[1]    = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			dram_get_i = 1'b0;
			sent       = 1'b0;
			first      = (pend[0] && pend[1]) ? int'(take_bits(1)) : 0;
			for (int j = 0; j < 2; j++) begin
				id = first ^ j;
				if (pend[id]) begin
					if (wait_cnt[id] != 0) begin
						wait_cnt[id]--;
					end else if (!sent) begin
						dram_get_i = 1'b1;
						dram_id_i  = id[0];
						for (int c = 0; c < 4; c++) begin
							occ_k_i[c] = occ_count(pos_k[id], c);
							occ_l_i[c] = occ_count(pos_l[id], c);
						end
						pend[id] = 1'b0;
						sent     = 1'b1;
					end
				end
			end
			@(negedge clk);
			if (!rst && dram_valid_o) begin
				id = int'(dram_id_o);
				if (pend[id])
					fail_run($sformatf("second memory request for id %0d before its answer",
						id));
				pend[id]     = 1'b1;
				wait_cnt[id] = int'(take_bits(3)); // latency 1 to 8
				pos_k[id]    = addr_k_o;
				pos_l[id]    = addr_l_o;
			end
		end
	end

	// ------------------------------
	// output comparison
	task automatic compare_output();
		bwt_pkg::result_t act;
		int               d;
		int               n;
		check_finish($sformatf("finish flag after %0d results", out_count),
			out_count == 2 * BATCH, output_finish_o);
		if (output_valid_o) begin
			act = output_data_o;
			d   = int'(act.dir);
			n   = int'(act.read_num);
			if (output_finish_o)
				fail_run("output strobe seen after the finish flag");
			if (n >= BATCH)
				fail_run($sformatf("result for unknown read number %0d", n));
			if (seen[d][n])
				fail_run($sformatf("second result for read %0d direction %0d", n, d));
			seen[d][n] = 1'b1;
			out_count++;
			check_result($sformatf("read %0d %s", n, (d == 0) ? "forward" : "backward"),
				exp_res[d][n], act);
		end
	endtask

	always @(negedge clk)
		if (!rst)
			compare_output();

	always @(negedge clk)
		if (u_dut.u_chk.fail_cnt != 0)
			fail_run("an assertion in the bound checker failed");

	initial begin
		repeat (WD_CYCLES) @(posedge clk);
		fail_run($sformatf("watchdog expired after %0d cycles", WD_CYCLES));
	end

endmodule

/* vlog.f */
+incdir+.
bwt_pkg.sv
load_pkg.sv
read_store.sv
bwt_extender.sv
occ_arbiter.sv
result_store.sv
smem_top.sv
tb_smem_chk.sv
tb_smem.sv

/* Bender.yml */
package:
  name: smem_seed

export_include_dirs:
  - .

sources:
  - bwt_pkg.sv
  - load_pkg.sv
  - read_store.sv
  - bwt_extender.sv
  - occ_arbiter.sv
  - result_store.sv
  - smem_top.sv
  - target: test
    files:
      - tb_smem_chk.sv
      - tb_smem.sv
